//--- verilog/channel_pkg.sv
`default_nettype none

package channel_pkg;

	//////////////////////////////////////////////////
	// block geometry
	localparam int NG_NUM     = 4;                  // segments per block
	localparam int SEG_LEN    = 32;                 // symbols per segment
	localparam int QUAN_SIZE  = 4;                  // bits per channel message
	localparam int SEG_W      = SEG_LEN * QUAN_SIZE;
	localparam int PIPE_DEPTH = 3;                  // issue to message

	//////////////////////////////////////////////////
	// noise and quantisation
	localparam int BPSK_ONE      = 64;   // level of +1.0
	localparam int NOISE_SHIFT   = 9;
	localparam int QUANT_SHIFT   = 4;
	localparam int SAMPLE_OFFSET = 510;  // mean of four byte sum
	localparam int MSG_MAX       = 2 ** (QUAN_SIZE - 1) - 1;
	localparam int MSG_MIN       = -(2 ** (QUAN_SIZE - 1));

	typedef logic [31:0]         urng_word_t;
	typedef logic [15:0]         sigma_t;    // Q8.8
	typedef logic signed [17:0]  level_t;
	typedef logic signed [QUAN_SIZE-1:0] ch_msg_t;
	typedef logic [SEG_W-1:0]    segment_t;
	typedef logic [5:0]          sym_cnt_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN,
		FULL
	} seg_state_t;

	// xorshift must never hold zero
	localparam urng_word_t URNG_RESET = 32'h0000_0001;
	localparam urng_word_t SEED_BASE [NG_NUM] = '{
		32'h2545_f491,
		32'h9e37_79b9,
		32'h6c07_8965,
		32'hd1b5_4a32
	};

endpackage

`default_nettype wire

//--- verilog/wb_regs_pkg.sv
`default_nettype none

package wb_regs_pkg;

	localparam int WB_DW = 32;
	localparam int WB_AW = 4;   // byte address

	typedef logic [WB_DW-1:0] wb_data_t;
	typedef logic [WB_AW-1:0] wb_addr_t;
	typedef logic [15:0]      blk_cnt_t;

	//////////////////////////////////////////////////
	// word addresses
	localparam logic [WB_AW-3:0] REG_CTRL   = 2'd0;  // bit 0 run
	localparam logic [WB_AW-3:0] REG_SIGMA  = 2'd1;
	localparam logic [WB_AW-3:0] REG_SEED   = 2'd2;
	localparam logic [WB_AW-3:0] REG_STATUS = 2'd3;  // read only

	localparam logic [15:0] SIGMA_RESET = 16'd0;

endpackage

`default_nettype wire

//--- verilog/noise_urng.sv
`timescale 1ns/100ps
`default_nettype none

module noise_urng (
	input  wire                          sys_clk,
	input  wire                          rstn,
	input  wire                          seed_load_i,
	input  wire channel_pkg::urng_word_t seed_i,
	input  wire                          adv_i,
	output channel_pkg::urng_word_t      rnd_o
);
	import channel_pkg::*;

	urng_word_t rnd_next;

	// one xorshift32 step
	function automatic urng_word_t xorshift32(input urng_word_t x);
		urng_word_t s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	assign rnd_next = xorshift32(rnd_o);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			rnd_o <= URNG_RESET;
		end else if (seed_load_i) begin
			rnd_o <= seed_i;  // load wins over advance
		end else if (adv_i) begin
			rnd_o <= rnd_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/awgn_symbol_gen.sv
`timescale 1ns/100ps
`default_nettype none

module awgn_symbol_gen (
	input  wire                          sys_clk,
	input  wire                          rstn,
	input  wire                          seed_load_i,
	input  wire channel_pkg::urng_word_t seed_i,
	input  wire                          issue_i,
	input  wire channel_pkg::sigma_t     sigma_i,
	output channel_pkg::ch_msg_t         msg_o,
	output logic                         msg_valid_o
);
	import channel_pkg::*;

	urng_word_t            rnd;
	logic [9:0]            byte_sum;
	logic signed [10:0]    sample_q;
	logic signed [27:0]    noise_prod;
	level_t                level_q;
	level_t                level_sh;
	logic [PIPE_DEPTH-1:0] vld_q;

	// word is fresh on the cycle after issue
	noise_urng noise_urng_inst (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.seed_load_i (seed_load_i),
		.seed_i      (seed_i),
		.adv_i       (issue_i),
		.rnd_o       (rnd)
	);

	//////////////////////////////////////////////////
	// valid tag beside the data
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			vld_q       <= '0;
			msg_valid_o <= 1'b0;
		end else begin
			vld_q       <= {vld_q[PIPE_DEPTH-2:0], issue_i};
			msg_valid_o <= vld_q[PIPE_DEPTH-1];
		end
	end

	//////////////////////////////////////////////////
	// stage 1, central limit over four bytes
	assign byte_sum = rnd[7:0] + rnd[15:8] + rnd[23:16] + rnd[31:24];

	always_ff @(posedge sys_clk) begin
		sample_q <= $signed({1'b0, byte_sum}) - 11'(SAMPLE_OFFSET);  // -510..510
	end

	//////////////////////////////////////////////////
	// stage 2, scale by sigma and add +1.0
	assign noise_prod = sample_q * $signed({1'b0, sigma_i});

	always_ff @(posedge sys_clk) begin
		level_q <= level_t'(noise_prod >>> NOISE_SHIFT) + level_t'(BPSK_ONE);
	end

	//////////////////////////////////////////////////
	// stage 3, quantise and saturate
	assign level_sh = level_q >>> QUANT_SHIFT;

	always_ff @(posedge sys_clk) begin
		if (level_sh > level_t'(MSG_MAX)) begin
			msg_o <= ch_msg_t'(MSG_MAX);
		end else if (level_sh < level_t'(MSG_MIN)) begin
			msg_o <= ch_msg_t'(MSG_MIN);
		end else begin
			msg_o <= level_sh[QUAN_SIZE-1:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/segment_gen.sv
`timescale 1ns/100ps
`default_nettype none

module segment_gen (
	input  wire                          sys_clk,
	input  wire                          rstn,
	input  wire                          run_i,
	input  wire channel_pkg::sigma_t     sigma_i,
	input  wire                          seed_load_i,
	input  wire channel_pkg::urng_word_t seed_i,
	output channel_pkg::segment_t        seg_o,
	output logic                         seg_valid_o,
	input  wire                          seg_ready_i,
	output logic                         busy_o
);
	import channel_pkg::*;

	seg_state_t state_q;
	sym_cnt_t   issue_cnt_q;
	sym_cnt_t   msg_cnt_q;
	sigma_t     sigma_q;
	segment_t   shift_q;
	ch_msg_t    msg;
	logic       msg_valid;
	logic       issue;
	logic       seg_done;
	logic       hold_free;
	logic       hand_over;
	logic       blk_start;

	assign issue     = (state_q == RUN);
	assign seg_done  = (msg_cnt_q == sym_cnt_t'(SEG_LEN));
	assign hold_free = ~seg_valid_o | seg_ready_i;  // empty or emptied now
	assign hand_over = ((state_q == DRAIN) || (state_q == FULL)) && seg_done && hold_free;
	assign blk_start = run_i && ((state_q == IDLE) || hand_over);
	assign busy_o    = (state_q != IDLE) | seg_valid_o;

	awgn_symbol_gen awgn_symbol_gen_inst (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.seed_load_i (seed_load_i),
		.seed_i      (seed_i),
		.issue_i     (issue),
		.sigma_i     (sigma_q),
		.msg_o       (msg),
		.msg_valid_o (msg_valid)
	);

	//////////////////////////////////////////////////
	// block FSM
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state_q     <= IDLE;
			issue_cnt_q <= '0;
			sigma_q     <= '0;
		end else begin
			if (blk_start)
				sigma_q <= sigma_i;  // fixed for the whole block
			case (state_q)
				IDLE: if (run_i) state_q <= RUN;
				RUN: begin
					if (issue_cnt_q == sym_cnt_t'(SEG_LEN - 1)) begin
						state_q     <= DRAIN;
						issue_cnt_q <= '0;
					end else begin
						issue_cnt_q <= issue_cnt_q + 1'b1;
					end
				end
				DRAIN, FULL: begin
					if (hand_over)
						state_q <= run_i ? RUN : IDLE;
					else if (seg_done)
						state_q <= FULL;  // holding register still occupied
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// messages captured for the block being collected
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			msg_cnt_q <= '0;
		else if (hand_over)
			msg_cnt_q <= '0;
		else if (msg_valid)
			msg_cnt_q <= msg_cnt_q + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (msg_valid)
			shift_q <= {shift_q[SEG_W-QUAN_SIZE-1:0], msg};  // symbol 0 ends on top
	end

	//////////////////////////////////////////////////
	// holding register, valid/ready
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			seg_valid_o <= 1'b0;
		else if (hand_over)
			seg_valid_o <= 1'b1;
		else if (seg_ready_i)
			seg_valid_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (hand_over)
			seg_o <= shift_q;
	end

endmodule

`default_nettype wire

//--- verilog/wb_channel_regs.sv
`timescale 1ns/100ps
`default_nettype none

module wb_channel_regs (
	input  wire                          sys_clk,
	input  wire                          rstn,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wire wb_regs_pkg::wb_addr_t   wb_adr_i,
	input  wire wb_regs_pkg::wb_data_t   wb_dat_i,
	output wb_regs_pkg::wb_data_t        wb_dat_o,
	output logic                         wb_ack_o,
	input  wire                          busy_i,
	input  wire                          accept_i,
	output logic                         run_o,
	output channel_pkg::sigma_t          sigma_o,
	output logic                         seed_load_o,
	output channel_pkg::urng_word_t      seed_o
);
	import channel_pkg::*;
	import wb_regs_pkg::*;

	logic             req;
	logic             wr_req;
	logic [WB_AW-3:0] word_adr;
	blk_cnt_t         blk_cnt_q;

	assign word_adr = wb_adr_i[WB_AW-1:2];
	assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // single cycle ack
	assign wr_req   = req & wb_we_i;

	//////////////////////////////////////////////////
	// control registers and ack
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			wb_ack_o    <= 1'b0;
			run_o       <= 1'b0;
			sigma_o     <= SIGMA_RESET;
			seed_o      <= '0;
			seed_load_o <= 1'b0;
		end else begin
			wb_ack_o    <= req;
			seed_load_o <= wr_req && (word_adr == REG_SEED) && !busy_i;
			if (wr_req) begin
				case (word_adr)
					REG_CTRL:  run_o   <= wb_dat_i[0];
					REG_SIGMA: sigma_o <= wb_dat_i[$bits(sigma_t)-1:0];
					REG_SEED:  seed_o  <= wb_dat_i;
					default: ;  // STATUS is read only
				endcase
			end
		end
	end

	// accepted blocks, wraps
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			blk_cnt_q <= '0;
		else if (accept_i)
			blk_cnt_q <= blk_cnt_q + 1'b1;
	end

	//////////////////////////////////////////////////
	// read data, valid while ack is high
	always_ff @(posedge sys_clk) begin
		if (req && !wb_we_i) begin
			case (word_adr)
				REG_CTRL:  wb_dat_o <= wb_data_t'(run_o);
				REG_SIGMA: wb_dat_o <= wb_data_t'(sigma_o);
				REG_SEED:  wb_dat_o <= seed_o;
				default:   wb_dat_o <= {15'd0, busy_i, blk_cnt_q};
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/received_block_gen.sv
`timescale 1ns/100ps
`default_nettype none

module received_block_gen (
	input  wire                        sys_clk,
	input  wire                        rstn,
	input  wire                        wb_cyc_i,
	input  wire                        wb_stb_i,
	input  wire                        wb_we_i,
	input  wire wb_regs_pkg::wb_addr_t wb_adr_i,
	input  wire wb_regs_pkg::wb_data_t wb_dat_i,
	output wb_regs_pkg::wb_data_t      wb_dat_o,
	output logic                       wb_ack_o,
	output channel_pkg::segment_t      coded_block_0_o,
	output channel_pkg::segment_t      coded_block_1_o,
	output channel_pkg::segment_t      coded_block_2_o,
	output channel_pkg::segment_t      coded_block_3_o,
	output logic                       block_valid_o,
	input  wire                        block_ready_i
);
	import channel_pkg::*;

	logic              run;
	sigma_t            sigma;
	logic              seed_load;
	urng_word_t        seed_off;
	logic              accept;
	logic              busy_any;
	logic [NG_NUM-1:0] seg_valid;
	logic [NG_NUM-1:0] seg_busy;
	segment_t          seg_data [NG_NUM];

	assign block_valid_o = &seg_valid;  // segments run in lockstep
	assign busy_any      = |seg_busy;
	assign accept        = block_valid_o & block_ready_i;

	wb_channel_regs wb_channel_regs_inst (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.busy_i      (busy_any),
		.accept_i    (accept),
		.run_o       (run),
		.sigma_o     (sigma),
		.seed_load_o (seed_load),
		.seed_o      (seed_off)
	);

	//////////////////////////////////////////////////
	// one generator per segment, own seed
	for (genvar g = 0; g < NG_NUM; g++) begin : g_seg
		segment_gen segment_gen_inst (
			.sys_clk     (sys_clk),
			.rstn        (rstn),
			.run_i       (run),
			.sigma_i     (sigma),
			.seed_load_i (seed_load),
			.seed_i      (SEED_BASE[g] ^ seed_off),
			.seg_o       (seg_data[g]),
			.seg_valid_o (seg_valid[g]),
			.seg_ready_i (block_ready_i),
			.busy_o      (seg_busy[g])
		);
	end

	assign coded_block_0_o = seg_data[0];
	assign coded_block_1_o = seg_data[1];
	assign coded_block_2_o = seg_data[2];
	assign coded_block_3_o = seg_data[3];

endmodule

`default_nettype wire

//--- sim/tb_channel_model.svh
`ifndef TB_CHANNEL_MODEL_SVH
`define TB_CHANNEL_MODEL_SVH

//////////////////////////////////////////////////
// reference model, one xorshift state per segment
logic [31:0]      model_state [NG_NUM];
logic [15:0]      model_sigma;
logic [SEG_W-1:0] model_seg [NG_NUM];  // last block the model produced

function automatic logic [31:0] xorshift_next(input logic [31:0] x);
	logic [31:0] t;
	t = x ^ (x << 13);
	t = t ^ (t >> 17);
	return t ^ (t << 5);
endfunction

// four byte sum, scale, +1.0, quantise and clip
function automatic logic [3:0] channel_msg(input logic [31:0] w, input logic [15:0] sigma);
	int sample;
	int level;
	int q;
	sample = int'(w[7:0]) + int'(w[15:8]) + int'(w[23:16]) + int'(w[31:24]) - 510;
	level  = ((sample * int'(sigma)) >>> NOISE_SHIFT) + BPSK_ONE;
	q      = level >>> QUANT_SHIFT;
	if (q > 7)
		q = 7;
	else if (q < -8)
		q = -8;
	return q[3:0];
endfunction

task automatic model_reseed(input logic [31:0] offset);
	for (int g = 0; g < NG_NUM; g++)
		model_state[g] = SEED_BASE[g] ^ offset;
endtask

// next block, symbol 0 in the top nibble
task automatic model_next_block();
	logic [SEG_W-1:0] acc;
	for (int g = 0; g < NG_NUM; g++) begin
		acc = '0;
		for (int s = 0; s < SEG_LEN; s++) begin
			model_state[g] = xorshift_next(model_state[g]);
			acc = {acc[SEG_W-5:0], channel_msg(model_state[g], model_sigma)};
		end
		model_seg[g] = acc;
	end
endtask

`endif

//--- sim/tb_received_block_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_received_block_gen;
	import channel_pkg::*;
	import wb_regs_pkg::*;

	typedef struct packed {
		logic [15:0] sigma;
		logic [31:0] offset;
		logic [7:0]  n_blk;      // collected while run is set
		logic        rnd_ready;
		logic [3:0]  ref_row;    // row whose first block must come back
		logic [15:0] exp_cnt;    // STATUS count after the row
	} row_t;

	localparam int         NUM_ROWS   = 5;
	localparam int         BLK_CYCLES = 36;
	localparam logic [3:0] NO_REF     = 4'hf;

	logic     sys_clk;
	logic     rstn;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	segment_t blk [NG_NUM];
	logic     blk_valid;
	logic     blk_ready;

	row_t     rows [NUM_ROWS];
	segment_t first_blk [NUM_ROWS][NG_NUM];
	segment_t prev_blk [NG_NUM];
	logic     prev_valid;
	logic     prev_ready;
	integer   seed;
	int       cycle_cnt;
	int       cycle_limit;
	int       err_cnt;
	int       test_err;
	int       test_acc;
	int       total_acc;
	int       ready_mode;  // 0 low, 1 high, 2 random
	int       low_left;
	int       cur_row;

	`include "tb_channel_model.svh"

	received_block_gen received_block_gen_inst (
		.sys_clk         (sys_clk),
		.rstn            (rstn),
		.wb_cyc_i        (wb_cyc),
		.wb_stb_i        (wb_stb),
		.wb_we_i         (wb_we),
		.wb_adr_i        (wb_adr),
		.wb_dat_i        (wb_dat_w),
		.wb_dat_o        (wb_dat_r),
		.wb_ack_o        (wb_ack),
		.coded_block_0_o (blk[0]),
		.coded_block_1_o (blk[1]),
		.coded_block_2_o (blk[2]),
		.coded_block_3_o (blk[3]),
		.block_valid_o   (blk_valid),
		.block_ready_i   (blk_ready)
	);

	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: no end of test after %0d cycles", cycle_cnt);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [SEG_W-1:0] got,
			input logic [SEG_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %0h expected %0h", name, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	//////////////////////////////////////////////////
	// output side, checked on every cycle
	task automatic accept_block();
		string nm;
		model_next_block();
		for (int g = 0; g < NG_NUM; g++) begin
			nm = $sformatf("coded_block_%0d_o", g);
			check_val(nm, blk[g], model_seg[g]);
			if (rows[cur_row].sigma == 16'd0)
				check_val(nm, blk[g], {SEG_LEN{4'h4}});  // noiseless +1.0
			if (test_acc == 0) begin
				first_blk[cur_row][g] = blk[g];
				if (rows[cur_row].ref_row != NO_REF)
					check_val(nm, blk[g], first_blk[rows[cur_row].ref_row][g]);
			end
		end
		test_acc++;
		total_acc++;
		if (test_acc == rows[cur_row].n_blk - 1)
			ready_mode = 1;  // last block taken at once
	endtask

	task automatic clock_step();
		logic rdy;
		int   r;
		@(posedge sys_clk);
		#2;
		if (prev_valid && !prev_ready) begin
			check_val("block_valid_o", blk_valid, 1'b1);
			for (int g = 0; g < NG_NUM; g++)
				check_val($sformatf("coded_block_%0d_o", g), blk[g], prev_blk[g]);
		end
		case (ready_mode)
			1: rdy = 1'b1;
			2: begin
				if (low_left > 0) begin
					rdy = 1'b0;
					low_left--;
				end else begin
					r   = $random(seed);
					rdy = (r[1:0] != 2'b00);
					if (!rdy)
						low_left = r[4:2];  // up to 8 low cycles
				end
			end
			default: rdy = 1'b0;
		endcase
		blk_ready = rdy;
		if (blk_valid && rdy)
			accept_block();
		prev_valid = blk_valid;
		prev_ready = rdy;
		for (int g = 0; g < NG_NUM; g++)
			prev_blk[g] = blk[g];
	endtask

	//////////////////////////////////////////////////
	// wishbone classic transfers
	task automatic wait_ack();
		clock_step();
		while (!wb_ack)
			clock_step();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] word, input wb_data_t data);
		wb_adr   = {word, 2'b00};
		wb_dat_w = data;
		wb_we    = 1'b1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wait_ack();
	endtask

	task automatic wb_read(input logic [1:0] word, output wb_data_t data);
		wb_adr = {word, 2'b00};
		wb_we  = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wait_ack();
		data = wb_dat_r;  // registered, still valid
	endtask

	function automatic int timeout_limit();
		int blocks;
		int stall;
		blocks = 0;
		stall  = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			blocks += rows[i].n_blk + 1;
			if (rows[i].rnd_ready)
				stall += (rows[i].n_blk + 1) * 48;
		end
		return 2 * blocks * BLK_CYCLES + stall + 200;
	endfunction

	task automatic check_reset_state();
		wb_data_t d;
		test_err = 0;
		check_val("wb_ack_o", wb_ack, 1'b0);
		check_val("block_valid_o", blk_valid, 1'b0);
		wb_read(REG_SIGMA, d);
		check_val("SIGMA", d, '0);
		wb_read(REG_STATUS, d);
		check_val("STATUS", d, '0);
		repeat (50) begin
			clock_step();
			check_val("block_valid_o", blk_valid, 1'b0);  // run still 0
		end
		$display("test 0 reset state: %0d errors", test_err);
	endtask

	task automatic run_row(input int idx);
		wb_data_t d;
		cur_row  = idx;
		test_err = 0;
		test_acc = 0;
		wb_write(REG_SEED, rows[idx].offset);
		model_reseed(rows[idx].offset);
		wb_write(REG_SIGMA, 32'(rows[idx].sigma));
		model_sigma = rows[idx].sigma;
		ready_mode  = rows[idx].rnd_ready ? 2 : 1;
		wb_write(REG_CTRL, 32'd1);
		while (test_acc < rows[idx].n_blk)
			clock_step();
		wb_write(REG_CTRL, 32'd0);
		ready_mode = 1;  // drain the block already started
		d = 32'h0001_0000;
		while (d[16])
			wb_read(REG_STATUS, d);
		ready_mode = 0;
		check_val("blocks accepted", test_acc, rows[idx].n_blk + 1);
		check_val("STATUS", d, {16'd0, rows[idx].exp_cnt});
		$display("test %0d sigma %0d: %0d blocks, %0d errors",
			idx + 1, rows[idx].sigma, test_acc, test_err);
	endtask

	//////////////////////////////////////////////////
	// stimulus table and main sequence
	initial begin
		sys_clk    = 1'b0;
		rstn       = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		blk_ready  = 1'b0;
		seed       = 32'h1c66_1225;
		cycle_cnt  = 0;
		err_cnt    = 0;
		total_acc  = 0;
		ready_mode = 0;
		low_left   = 0;
		cur_row    = 0;
		prev_valid = 1'b0;
		prev_ready = 1'b0;
		rows[0] = '{16'd0,    32'h0000_0000, 8'd3, 1'b0, NO_REF, 16'd4};
		rows[1] = '{16'd256,  32'h1234_5678, 8'd4, 1'b0, NO_REF, 16'd9};
		rows[2] = '{16'd1024, 32'h0bad_cafe, 8'd4, 1'b0, NO_REF, 16'd14};
		rows[3] = '{16'd256,  32'h5a5a_0001, 8'd5, 1'b1, NO_REF, 16'd20};
		rows[4] = '{16'd256,  32'h1234_5678, 8'd2, 1'b0, 4'd1,   16'd23};  // repeat row 1
		cycle_limit = timeout_limit();
		repeat (4) @(posedge sys_clk);
		#2;
		rstn = 1'b1;
		check_reset_state();
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		$display("%0d tests, %0d blocks, %0d errors", NUM_ROWS + 1, total_acc, err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
verilog/channel_pkg.sv
verilog/wb_regs_pkg.sv
verilog/noise_urng.sv
verilog/awgn_symbol_gen.sv
verilog/segment_gen.sv
verilog/wb_channel_regs.sv
verilog/received_block_gen.sv
sim/tb_received_block_gen.sv
